// ==== Bender.yml ====
package:
  name: tile_mem_top

sources:
  - files:
      - rtl/tile_mem_pkg.sv
      - rtl/cpu_mem_port.sv
      - rtl/dual_port_ram.sv
      - rtl/noc_out_arbiter.sv
      - rtl/tile_mem_top.sv
  - target: test
    files:
      - test/tb_tile_mem_top.sv

// ==== rtl/cpu_mem_port.sv ====
// **********************************************************************
// Processor side of the tile memory. Decodes local versus remote and
// shares RAM port B with the host, which always wins the port.
// A processor write stores the whole word when any strobe is set.
// The core must hold its request until cpu_ready. Remote accesses end
// on remote_ready, which must not follow a local ready directly.
// **********************************************************************

`timescale 1ns/1ps

module cpu_mem_port
  import tile_mem_pkg::*;
#(
  parameter int OFFSET_W = 12,
  parameter int XY_W     = 3
) (
  input  logic                clk_ctrl,
  input  logic                clk_line_rst_low,
  input  logic [2*XY_W-1:0]   tile_id,
  input  cpu_req_t            cpu_req,
  input  mem_req_t            axi_req,
  input  logic                remote_ready,
  input  word_t               remote_rdata,
  input  word_t               ram_rdata,
  output mem_req_t            ram_req,
  output logic                cpu_ready,
  output word_t               cpu_rdata,
  output cpu_req_t            remote_req,
  output word_t               axi_rdata
);

  // **********************************************************************
  // Address decode
  // **********************************************************************

  word_t             word_addr;
  region_t           region;
  logic [2*XY_W-1:0] tile_field;
  logic              is_local;
  logic              cpu_grant;
  logic              cpu_owned_q;   // Port B served the processor last cycle

  assign word_addr  = cpu_req.addr >> 2;   // Bytes to words
  assign region     = cpu_req.addr[31:28];
  assign tile_field = word_addr[OFFSET_W+2*XY_W-1:OFFSET_W];

  // Fetches always stay in the tile
  assign is_local = cpu_req.instr ||
                    ((region == ARRAY_REGION) && (tile_field == tile_id));

  always_comb begin
    remote_req       = cpu_req;
    remote_req.valid = cpu_req.valid & ~is_local;
  end

  // **********************************************************************
  // Port B sharing
  // **********************************************************************

  // No new access in the ready cycle, the core still holds the old request
  assign cpu_grant = cpu_req.valid & is_local & ~axi_req.valid & ~cpu_owned_q;

  always_comb begin
    ram_req = '0;
    if (axi_req.valid) begin
      ram_req = axi_req;              // Host first
    end else begin
      ram_req.valid                 = cpu_grant;
      ram_req.we                    = |cpu_req.wstrb;
      ram_req.addr[OFFSET_W-1:0]    = word_addr[OFFSET_W-1:0];
      ram_req.wdata                 = cpu_req.wdata;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (!clk_line_rst_low) begin
      cpu_owned_q <= 1'b0;
    end else begin
      cpu_owned_q <= cpu_grant;
    end
  end

  // **********************************************************************
  // Response return
  // **********************************************************************

  assign cpu_ready = cpu_owned_q | (remote_req.valid & remote_ready);
  assign cpu_rdata = cpu_owned_q ? ram_rdata : remote_rdata;
  assign axi_rdata = ram_rdata;   // Host reads land one cycle later

  // A ready pulse closes one request, the core needs a cycle to move on
  a_ready_single : assert property (
    @(posedge clk_ctrl) disable iff (!clk_line_rst_low)
    cpu_ready |=> !cpu_ready
  ) else $error("cpu_ready high in two consecutive cycles");

endmodule

// ==== rtl/dual_port_ram.sv ====
// **********************************************************************
// Word memory with two synchronous read/write ports on one clock.
// Reads return the old word on a write. Port B wins a write collision.
// Callers pass word addresses below 2**OFFSET_W.
// **********************************************************************

`timescale 1ns/1ps

module dual_port_ram
  import tile_mem_pkg::*;
#(
  parameter int OFFSET_W = 12
) (
  input  logic     clk_ctrl,
  input  mem_req_t port_a_req,
  input  mem_req_t port_b_req,
  output word_t    port_a_rdata,
  output word_t    port_b_rdata
);

  localparam int DEPTH = 2 ** OFFSET_W;

  word_t    mem [DEPTH];
  mem_req_t port_req [2];   // Index 0 is A, 1 is B
  word_t    rdata_q [2];

  assign port_req[0] = port_a_req;
  assign port_req[1] = port_b_req;

  // Higher index written last, so B overrides A
  always_ff @(posedge clk_ctrl) begin
    for (int i = 0; i < 2; i++) begin
      if (port_req[i].valid) begin
        rdata_q[i] <= mem[port_req[i].addr[OFFSET_W-1:0]];
        if (port_req[i].we) begin
          mem[port_req[i].addr[OFFSET_W-1:0]] <= port_req[i].wdata;
        end
      end
    end
  end

  assign port_a_rdata = rdata_q[0];
  assign port_b_rdata = rdata_q[1];

  // Upper bits would alias onto another word
  for (genvar g = 0; g < 2; g++) begin : g_addr_chk
    a_addr_range : assert property (
      @(posedge clk_ctrl)
      port_req[g].valid |-> ((port_req[g].addr >> OFFSET_W) == '0)
    ) else $error("RAM port %0d address 0x%08x out of range", g, port_req[g].addr);
  end

endmodule

// ==== rtl/noc_out_arbiter.sv ====
// **********************************************************************
// Merges the refill and queue streams onto one network output.
// Refill wins when idle. A packet is never interleaved with another
// once its first non-last beat has transferred. No added latency,
// so stream_out is combinational from the selected source.
// **********************************************************************

`timescale 1ns/1ps

module noc_out_arbiter
  import tile_mem_pkg::*;
(
  input  logic  clk_ctrl,
  input  logic  clk_line_rst_low,
  input  axis_t refill_in,
  input  axis_t queue_in,
  input  logic  stream_out_ready,
  output logic  refill_ready,
  output logic  queue_ready,
  output axis_t stream_out
);

  arb_state_t state_q;
  arb_state_t state_d;
  arb_state_t sel;      // Source driving the output this cycle
  logic       xfer;

  // **********************************************************************
  // Source select
  // **********************************************************************

  always_comb begin
    sel = state_q;                         // Locked owner keeps the output
    if (state_q == ARB_IDLE) begin
      if (refill_in.valid) begin
        sel = ARB_REFILL;
      end else if (queue_in.valid) begin
        sel = ARB_QUEUE;
      end
    end
  end

  always_comb begin
    stream_out   = '0;
    refill_ready = 1'b0;
    queue_ready  = 1'b0;
    unique case (sel)
      ARB_REFILL: begin
        stream_out   = refill_in;
        refill_ready = stream_out_ready;   // Ready only to the owner
      end
      ARB_QUEUE: begin
        stream_out  = queue_in;
        queue_ready = stream_out_ready;
      end
      default: ;                           // Nothing pending
    endcase
  end

  // **********************************************************************
  // Packet lock FSM
  // **********************************************************************

  assign xfer = stream_out.valid & stream_out_ready;

  always_comb begin
    state_d = state_q;
    if (xfer) begin
      // One-beat packets leave the FSM idle
      state_d = stream_out.last ? ARB_IDLE : sel;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (!clk_line_rst_low) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // **********************************************************************
  // Checks
  // **********************************************************************

  a_refill_owner : assert property (
    @(posedge clk_ctrl) disable iff (!clk_line_rst_low)
    (state_q == ARB_REFILL && stream_out.valid) |-> refill_in.valid
  ) else $error("Output valid without refill valid while refill owns the output");

  a_queue_owner : assert property (
    @(posedge clk_ctrl) disable iff (!clk_line_rst_low)
    (state_q == ARB_QUEUE && stream_out.valid) |-> queue_in.valid
  ) else $error("Output valid without queue valid while queue owns the output");

  a_one_ready : assert property (
    @(posedge clk_ctrl) disable iff (!clk_line_rst_low)
    !(refill_ready && queue_ready)
  ) else $error("Both source readies high");

endmodule

// ==== rtl/tile_mem_pkg.sv ====
// **********************************************************************
// Shared types for the tile memory and network-output fabric.
// All widths are fixed at 32-bit words. Address widths that depend on
// the tile size are module parameters and do not live here.
// **********************************************************************

package tile_mem_pkg;

  // **********************************************************************
  // Plain vector types
  // **********************************************************************

  typedef logic [31:0] word_t;    // Data or address word
  typedef logic [3:0]  keep_t;    // Byte enables of a stream beat
  typedef logic [3:0]  wstrb_t;   // Processor byte write strobes
  typedef logic [3:0]  region_t;  // Byte-address bits 31..28

  // Region tag of the distributed array
  localparam region_t ARRAY_REGION = 4'h1;

  // **********************************************************************
  // Bundles
  // **********************************************************************

  // Processor bus request, 70 bits
  typedef struct packed {
    logic   valid;
    logic   instr;   // Instruction fetch
    word_t  addr;    // Byte address
    word_t  wdata;
    wstrb_t wstrb;
  } cpu_req_t;

  // Memory port request, 66 bits
  typedef struct packed {
    logic  valid;
    logic  we;
    word_t addr;     // Word address
    word_t wdata;
  } mem_req_t;

  // Stream beat with its valid, 38 bits
  typedef struct packed {
    logic  valid;
    word_t data;
    keep_t keep;
    logic  last;
  } axis_t;

  // Output arbiter owner
  typedef enum logic [1:0] {
    ARB_IDLE   = 2'd0,
    ARB_REFILL = 2'd1,
    ARB_QUEUE  = 2'd2
  } arb_state_t;

endpackage

// ==== rtl/tile_mem_top.sv ====
// **********************************************************************
// Memory and network-output fabric of one processor tile.
// Port A of the RAM belongs to the network engine, port B is shared
// by the host and the processor. Single clock, synchronous reset.
// Tile ID field sits just above the OFFSET_W word-offset bits.
// **********************************************************************

`timescale 1ns/1ps

module tile_mem_top
  import tile_mem_pkg::*;
#(
  parameter int OFFSET_W = 12,   // Memory depth is 2**OFFSET_W words
  parameter int XY_W     = 3     // Bits per tile coordinate
) (
  input  logic              clk_ctrl,
  input  logic              clk_line_rst_low,
  input  logic [2*XY_W-1:0] tile_id,
  // Processor bus
  input  cpu_req_t          cpu_req,
  output logic              cpu_ready,
  output word_t             cpu_rdata,
  // Remote path
  output cpu_req_t          remote_req,
  input  logic              remote_ready,
  input  word_t             remote_rdata,
  // Host and network memory ports
  input  mem_req_t          axi_req,
  output word_t             axi_rdata,
  input  mem_req_t          noc_mem_req,
  output word_t             noc_mem_rdata,
  // Outgoing streams
  input  axis_t             refill_in,
  output logic              refill_ready,
  input  axis_t             queue_in,
  output logic              queue_ready,
  output axis_t             stream_out,
  input  logic              stream_out_ready
);

  mem_req_t ram_req_b;
  word_t    ram_rdata_b;

  cpu_mem_port #(
    .OFFSET_W (OFFSET_W),
    .XY_W     (XY_W)
  ) i_cpu_mem_port (
    .clk_ctrl         (clk_ctrl),
    .clk_line_rst_low (clk_line_rst_low),
    .tile_id          (tile_id),
    .cpu_req          (cpu_req),
    .axi_req          (axi_req),
    .remote_ready     (remote_ready),
    .remote_rdata     (remote_rdata),
    .ram_rdata        (ram_rdata_b),
    .ram_req          (ram_req_b),
    .cpu_ready        (cpu_ready),
    .cpu_rdata        (cpu_rdata),
    .remote_req       (remote_req),
    .axi_rdata        (axi_rdata)
  );

  dual_port_ram #(
    .OFFSET_W (OFFSET_W)
  ) i_dual_port_ram (
    .clk_ctrl     (clk_ctrl),
    .port_a_req   (noc_mem_req),   // Network engine
    .port_b_req   (ram_req_b),     // Host or processor
    .port_a_rdata (noc_mem_rdata),
    .port_b_rdata (ram_rdata_b)
  );

  noc_out_arbiter i_noc_out_arbiter (
    .clk_ctrl         (clk_ctrl),
    .clk_line_rst_low (clk_line_rst_low),
    .refill_in        (refill_in),
    .queue_in         (queue_in),
    .stream_out_ready (stream_out_ready),
    .refill_ready     (refill_ready),
    .queue_ready      (queue_ready),
    .stream_out       (stream_out)
  );

endmodule

// ==== test/tb_tile_mem_top.sv ====
// **********************************************************************
// Testbench for the tile memory fabric. Runs one tile with OFFSET_W 12
// and XY_W 3. Inputs change on the falling edge of clk_ctrl.
// Memory rows and stream packets come from tables in this file.
// Stops at the first mismatch or timeout.
// **********************************************************************

`timescale 1ns/1ps

module tb_tile_mem_top
  import tile_mem_pkg::*;
();

  localparam int           OFFSET_W       = 12;
  localparam int           XY_W           = 3;
  localparam logic [5:0]   TILE_ID        = 6'h05;
  localparam logic [5:0]   OTHER_TILE     = 6'h2a;
  localparam int           TIMEOUT        = 20;    // Cycles for one handshake
  localparam int           STREAM_TIMEOUT = 200;

  typedef enum {OP_HW, OP_HR, OP_PW, OP_PR, OP_PF, OP_NW, OP_NR, OP_PR_BUSY} op_t;

  typedef struct {
    string name;
    op_t   op;
    word_t addr;      // Byte address for the processor, word address otherwise
    word_t data;
    word_t remote;    // remote_rdata driven for a remote access
    word_t expected;
  } mem_row_t;

  logic              clk_ctrl;
  logic              clk_line_rst_low;
  logic [2*XY_W-1:0] tile_id;
  cpu_req_t          cpu_req;
  logic              cpu_ready;
  word_t             cpu_rdata;
  cpu_req_t          remote_req;
  logic              remote_ready;
  word_t             remote_rdata;
  mem_req_t          axi_req;
  word_t             axi_rdata;
  mem_req_t          noc_mem_req;
  word_t             noc_mem_rdata;
  axis_t             refill_in;
  logic              refill_ready;
  axis_t             queue_in;
  logic              queue_ready;
  axis_t             stream_out;
  logic              stream_out_ready;

  mem_row_t rows[$];
  axis_t    refill_tbl[$];
  axis_t    queue_tbl[$];
  axis_t    expect_q[$];
  int       seed;

  tile_mem_top #(
    .OFFSET_W (OFFSET_W),
    .XY_W     (XY_W)
  ) i_tile_mem_top (
    .clk_ctrl         (clk_ctrl),
    .clk_line_rst_low (clk_line_rst_low),
    .tile_id          (tile_id),
    .cpu_req          (cpu_req),
    .cpu_ready        (cpu_ready),
    .cpu_rdata        (cpu_rdata),
    .remote_req       (remote_req),
    .remote_ready     (remote_ready),
    .remote_rdata     (remote_rdata),
    .axi_req          (axi_req),
    .axi_rdata        (axi_rdata),
    .noc_mem_req      (noc_mem_req),
    .noc_mem_rdata    (noc_mem_rdata),
    .refill_in        (refill_in),
    .refill_ready     (refill_ready),
    .queue_in         (queue_in),
    .queue_ready      (queue_ready),
    .stream_out       (stream_out),
    .stream_out_ready (stream_out_ready)
  );

  always #2 clk_ctrl = ~clk_ctrl;   // 4 ns period

  // **********************************************************************
  // Helpers
  // **********************************************************************

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR: %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  // Tile field sits in word-address bits just above the offset
  function automatic word_t byte_addr(input region_t region, input logic [5:0] tile,
                                      input int offset);
    word_t a;
    a = {region, 28'h0};
    a = a | (word_t'(tile) << (OFFSET_W + 2));
    a = a | (word_t'(offset) << 2);
    return a;
  endfunction

  function automatic logic expect_local(input logic instr, input word_t addr);
    logic [2*XY_W-1:0] tile;
    tile = addr[OFFSET_W+2*XY_W+1:OFFSET_W+2];
    return instr || ((addr[31:28] == ARRAY_REGION) && (tile == TILE_ID));
  endfunction

  function automatic axis_t make_beat(input word_t data, input keep_t keep, input logic last);
    axis_t b;
    b.valid = 1'b1;
    b.data  = data;
    b.keep  = keep;
    b.last  = last;
    return b;
  endfunction

  task automatic add_row(input string name, input op_t op, input word_t addr,
                         input word_t data, input word_t remote, input word_t expected);
    mem_row_t r;
    r.name     = name;
    r.op       = op;
    r.addr     = addr;
    r.data     = data;
    r.remote   = remote;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic wait_cpu_ready(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_ctrl);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("cpu_ready never rose during %s", name));
      end
    end while (!cpu_ready);
  endtask

  // **********************************************************************
  // Memory operations
  // **********************************************************************

  task automatic run_port(input mem_row_t r);
    mem_req_t req;
    logic     is_host;
    is_host   = (r.op == OP_HW) || (r.op == OP_HR);
    req.valid = 1'b1;
    req.we    = (r.op == OP_HW) || (r.op == OP_NW);
    req.addr  = r.addr;
    req.wdata = r.data;
    if (is_host) axi_req = req;
    else noc_mem_req = req;
    @(negedge clk_ctrl);
    if (!req.we) check_value(r.name, r.expected, is_host ? axi_rdata : noc_mem_rdata);
    axi_req     = '0;
    noc_mem_req = '0;
  endtask

  task automatic run_cpu(input mem_row_t r);
    logic local_acc;
    int   cycles;
    local_acc     = expect_local(r.op == OP_PF, r.addr);
    cpu_req       = '0;
    cpu_req.valid = 1'b1;
    cpu_req.instr = (r.op == OP_PF);
    cpu_req.addr  = r.addr;
    cpu_req.wdata = r.data;
    cpu_req.wstrb = (r.op == OP_PW) ? 4'hf : 4'h0;
    if (r.op == OP_PR_BUSY) begin
      axi_req       = '0;
      axi_req.valid = 1'b1;           // Host reads word 0 meanwhile
      repeat (3) begin
        @(negedge clk_ctrl);
        check_value({r.name, "_held"}, 0, cpu_ready);
      end
      axi_req = '0;
    end
    if (!local_acc) begin
      repeat (2) begin
        @(negedge clk_ctrl);
        check_value({r.name, "_remote_valid"}, 1, remote_req.valid);
        check_value({r.name, "_remote_addr"}, r.addr, remote_req.addr);
        check_value({r.name, "_early_ready"}, 0, cpu_ready);
      end
      remote_ready = 1'b1;
      remote_rdata = r.remote;
    end
    wait_cpu_ready(r.name, cycles);
    if (local_acc) begin
      check_value({r.name, "_latency"}, 1, cycles);
      check_value({r.name, "_remote_valid"}, 0, remote_req.valid);
    end
    if (r.op != OP_PW) check_value(r.name, r.expected, cpu_rdata);
    cpu_req      = '0;
    remote_ready = 1'b0;
  endtask

  // **********************************************************************
  // Stream merge
  // **********************************************************************

  // Refill shows up once the queue has moved refill_hold beats
  task automatic run_streams(input string name, input int refill_hold);
    int ri;
    int qi;
    int oi;
    int cycles;
    int rnd;
    ri     = 0;
    qi     = 0;
    oi     = 0;
    cycles = 0;
    while (oi < expect_q.size()) begin
      @(negedge clk_ctrl);
      refill_in        = (ri < refill_tbl.size() && qi >= refill_hold) ? refill_tbl[ri] : '0;
      queue_in         = (qi < queue_tbl.size()) ? queue_tbl[qi] : '0;
      rnd              = $random(seed);
      stream_out_ready = rnd[0];
      #1;                                 // Settled until the next rising edge
      if (!stream_out_ready) begin
        check_value({name, "_refill_ready_bp"}, 0, refill_ready);
        check_value({name, "_queue_ready_bp"}, 0, queue_ready);
      end
      if (stream_out.valid && stream_out_ready) begin
        check_value($sformatf("%s_beat%0d", name, oi), expect_q[oi], stream_out);
        oi++;
      end
      if (refill_in.valid && refill_ready) ri++;
      if (queue_in.valid && queue_ready) qi++;
      cycles++;
      if (cycles > STREAM_TIMEOUT) begin
        abort_run($sformatf("stream_out never delivered every beat during %s", name));
      end
    end
    @(negedge clk_ctrl);
    refill_in        = '0;
    queue_in         = '0;
    stream_out_ready = 1'b0;
    check_value({name, "_refill_used"}, refill_tbl.size(), ri);
    check_value({name, "_queue_used"}, queue_tbl.size(), qi);
  endtask

  // **********************************************************************
  // Sequence
  // **********************************************************************

  initial begin
    clk_ctrl         = 1'b0;
    clk_line_rst_low = 1'b0;
    tile_id          = TILE_ID;
    cpu_req          = '0;
    remote_ready     = 1'b0;
    remote_rdata     = '0;
    axi_req          = '0;
    noc_mem_req      = '0;
    refill_in        = '0;
    queue_in         = '0;
    stream_out_ready = 1'b0;
    seed             = 32'h312f2730;

    // Local read pending through reset must not complete
    cpu_req.valid = 1'b1;
    cpu_req.addr  = byte_addr(ARRAY_REGION, TILE_ID, 0);

    repeat (10) @(negedge clk_ctrl);
    check_value("reset_cpu_ready", 0, cpu_ready);
    cpu_req          = '0;
    clk_line_rst_low = 1'b1;
    @(negedge clk_ctrl);
    check_value("reset_cpu_ready_after", 0, cpu_ready);
    check_value("reset_stream_valid", 0, stream_out.valid);

    // Name, op, address, data, remote data, expected
    add_row("host_wr_a", OP_HW, 32'h010, 32'ha5a5_0001, 0, 0);
    add_row("cpu_rd_a", OP_PR, byte_addr(1, TILE_ID, 'h010), 0, 0, 32'ha5a5_0001);
    add_row("cpu_wr_b", OP_PW, byte_addr(1, TILE_ID, 'h011), 32'h1234_5678, 0, 0);
    add_row("host_rd_b", OP_HR, 32'h011, 0, 0, 32'h1234_5678);
    add_row("cpu_rd_busy", OP_PR_BUSY, byte_addr(1, TILE_ID, 'h011), 0, 0, 32'h1234_5678);
    add_row("noc_wr_c", OP_NW, 32'h020, 32'hc0de_0020, 0, 0);
    add_row("host_rd_c", OP_HR, 32'h020, 0, 0, 32'hc0de_0020);
    add_row("host_wr_d", OP_HW, 32'h030, 32'hd00d_0030, 0, 0);
    add_row("noc_rd_d", OP_NR, 32'h030, 0, 0, 32'hd00d_0030);
    add_row("remote_rd_tile", OP_PR, byte_addr(1, OTHER_TILE, 'h010), 0,
            32'hbeef_0001, 32'hbeef_0001);
    add_row("remote_wr_region", OP_PW, byte_addr(2, TILE_ID, 'h030), 32'hffff_ffff, 0, 0);
    add_row("host_rd_d2", OP_HR, 32'h030, 0, 0, 32'hd00d_0030);
    add_row("remote_wr_tile", OP_PW, byte_addr(1, OTHER_TILE, 'h020), 32'hffff_ffff, 0, 0);
    add_row("host_rd_c2", OP_HR, 32'h020, 0, 0, 32'hc0de_0020);
    add_row("fetch_foreign", OP_PF, byte_addr(1, OTHER_TILE, 'h011), 0, 0, 32'h1234_5678);

    foreach (rows[i]) begin
      if (rows[i].op inside {OP_PR, OP_PW, OP_PF, OP_PR_BUSY}) run_cpu(rows[i]);
      else run_port(rows[i]);
      @(negedge clk_ctrl);                // One idle cycle between rows
    end

    // Both pending together, refill goes first as a whole packet
    refill_tbl = '{make_beat(32'h5100_0000, 4'hf, 1'b0), make_beat(32'h5100_0001, 4'h3, 1'b0),
                   make_beat(32'h5100_0002, 4'h1, 1'b1)};
    queue_tbl  = '{make_beat(32'h9900_0000, 4'hf, 1'b0), make_beat(32'h9900_0001, 4'hc, 1'b1)};
    expect_q   = {refill_tbl, queue_tbl};
    run_streams("merge", 0);

    // Queue holds the output, refill waits for the queue's last beat
    refill_tbl = '{make_beat(32'h5200_0000, 4'hf, 1'b0), make_beat(32'h5200_0001, 4'h1, 1'b1)};
    queue_tbl  = '{make_beat(32'h9a00_0000, 4'hf, 1'b0), make_beat(32'h9a00_0001, 4'h3, 1'b0),
                   make_beat(32'h9a00_0002, 4'hc, 1'b1)};
    expect_q   = {queue_tbl, refill_tbl};
    run_streams("locked", 1);

    refill_tbl = {};
    queue_tbl  = '{make_beat(32'h9900_00aa, 4'h7, 1'b1)};
    expect_q   = queue_tbl;
    run_streams("one_beat", 0);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tile_mem_top.f ====
rtl/tile_mem_pkg.sv
rtl/cpu_mem_port.sv
rtl/dual_port_ram.sv
rtl/noc_out_arbiter.sv
rtl/tile_mem_top.sv
test/tb_tile_mem_top.sv
